// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

  ////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////

  // Register address and data word
  typedef logic [4:0]  rf_addr_t;
  typedef logic [31:0] word_t;

  // Opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // ALU operation, add unless funct7 says subtract
  typedef enum logic {
    ALU_ADD = 1'b0,
    ALU_SUB = 1'b1
  } alu_op_e;

  // Operand source picked by the bypass controller
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  ////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////

  // Register-register format
  typedef struct packed {
    logic [6:0] funct7;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    rf_addr_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  // Immediate format, used by ADDI and LW
  typedef struct packed {
    logic [11:0] imm12;
    rf_addr_t    rs1;
    logic [2:0]  funct3;
    rf_addr_t    rd;
    opcode_e     opcode;
  } i_fmt_t;

  // Store format, immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  // One 32-bit word, three ways to read it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
  } instr_u;

endpackage

`default_nettype wire

// ==== src/id_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_decoder #(
  parameter int unsigned RF_NUM_READ_PORTS = 2
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         instr_valid_i,
  input  core_pkg::instr_u             instr_i,
  input  logic                         stall_i,
  output logic [RF_NUM_READ_PORTS-1:0] rf_re_o,
  output core_pkg::rf_addr_t           rf_raddr_o [RF_NUM_READ_PORTS],
  output logic                         rf_we_o,
  output core_pkg::rf_addr_t           rf_waddr_o,
  output core_pkg::alu_op_e            alu_op_o,
  output core_pkg::word_t              imm_o,
  output logic                         use_imm_o,
  output logic                         lsu_en_o,
  output logic                         lsu_we_o,
  output logic                         valid_o
);

  import core_pkg::*;

  // Fetch-to-decode register
  instr_u instr_q;
  logic   valid_q;
  // Writes rd before the r0 check
  logic   we_raw;

  // Valid bit is control state, word is payload
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= instr_valid_i;
    end
  end

  // Word held while the load-use stall is up
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      instr_q <= instr_i;
    end
  end

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  always_comb begin
    rf_re_o   = '0;
    we_raw    = 1'b0;
    alu_op_o  = ALU_ADD;
    imm_o     = '0;
    use_imm_o = 1'b0;
    lsu_en_o  = 1'b0;
    lsu_we_o  = 1'b0;
    for (int p = 0; p < RF_NUM_READ_PORTS; p++) begin
      rf_raddr_o[p] = '0;
    end
    // rs1 and rs2 sit at the same bits in every format
    rf_raddr_o[0] = instr_q.r.rs1;
    rf_raddr_o[1] = instr_q.r.rs2;

    case (instr_q.r.opcode)
      OP: begin
        rf_re_o[1:0] = 2'b11;
        we_raw       = 1'b1;
        // funct7 bit 5 separates SUB from ADD
        alu_op_o     = instr_q.r.funct7[5] ? ALU_SUB : ALU_ADD;
      end
      OP_IMM, LOAD: begin
        rf_re_o[0] = 1'b1;
        we_raw     = 1'b1;
        imm_o      = {{20{instr_q.i.imm12[11]}}, instr_q.i.imm12};
        use_imm_o  = 1'b1;
        lsu_en_o   = (instr_q.i.opcode == LOAD);
      end
      STORE: begin
        rf_re_o[1:0] = 2'b11;
        imm_o        = {{20{instr_q.s.imm_hi[6]}}, instr_q.s.imm_hi, instr_q.s.imm_lo};
        use_imm_o    = 1'b1;
        lsu_en_o     = 1'b1;
        lsu_we_o     = 1'b1;
      end
      // Unknown opcode: no write, no memory access
      default: ;
    endcase
  end

  // Writes to r0 are dropped here, so they never reach the result stage
  assign rf_we_o    = we_raw && (instr_q.r.rd != '0);
  assign rf_waddr_o = instr_q.r.rd;
  assign valid_o    = valid_q;

  // A store must only touch memory, never the register file
  a_store_no_rf_we: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (valid_o && (instr_q.s.opcode == STORE)) |-> (!rf_we_o && lsu_we_o)
  ) else $error("store decoded with register write");

endmodule

`default_nettype wire

// ==== src/controller_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module controller_bypass #(
  parameter int unsigned RF_NUM_READ_PORTS = 2
) (
  // Decode read side
  input  logic [RF_NUM_READ_PORTS-1:0] rf_re_id_i,
  input  core_pkg::rf_addr_t           rf_raddr_id_i [RF_NUM_READ_PORTS],
  input  logic                         id_valid_i,
  // Execute write side
  input  logic                         rf_we_ex_i,
  input  core_pkg::rf_addr_t           rf_waddr_ex_i,
  input  logic                         lsu_en_ex_i,
  input  logic                         ex_valid_i,
  // Result write side
  input  logic                         rf_we_wb_i,
  input  core_pkg::rf_addr_t           rf_waddr_wb_i,
  input  logic                         wb_valid_i,
  // Bypass and stall
  output core_pkg::fw_sel_e            operand_a_fw_sel_o,
  output core_pkg::fw_sel_e            operand_b_fw_sel_o,
  output logic                         load_stall_o
);

  import core_pkg::*;

  // Address matches, already gated with read enable and r0
  logic [RF_NUM_READ_PORTS-1:0] rf_rd_ex_match;
  logic [RF_NUM_READ_PORTS-1:0] rf_rd_wb_match;

  // Write enables qualified with stage valid
  logic rf_we_ex;
  logic rf_we_wb;
  // Load sitting in execute
  logic load_ex;

  assign rf_we_ex = rf_we_ex_i && ex_valid_i;
  assign rf_we_wb = rf_we_wb_i && wb_valid_i;
  // Stores never set rf_we, so this is a load
  assign load_ex  = lsu_en_ex_i && rf_we_ex;

  ////////////////////////////////////////
  // Address compare
  ////////////////////////////////////////

  for (genvar i = 0; i < RF_NUM_READ_PORTS; i++) begin : gen_match
    // ID read vs EX write, r0 never matches
    assign rf_rd_ex_match[i] = (rf_waddr_ex_i == rf_raddr_id_i[i]) && |rf_raddr_id_i[i] &&
                               rf_re_id_i[i] && id_valid_i;
    // ID read vs WB write
    assign rf_rd_wb_match[i] = (rf_waddr_wb_i == rf_raddr_id_i[i]) && |rf_raddr_id_i[i] &&
                               rf_re_id_i[i] && id_valid_i;
  end

  // Load result only exists one cycle later, hold decode
  assign load_stall_o = load_ex && |rf_rd_ex_match;

  ////////////////////////////////////////
  // Forwarding select
  ////////////////////////////////////////

  always_comb begin
    operand_a_fw_sel_o = SEL_REGFILE;
    operand_b_fw_sel_o = SEL_REGFILE;

    // Result stage first
    if (rf_we_wb) begin
      if (rf_rd_wb_match[0]) begin
        operand_a_fw_sel_o = SEL_FW_WB;
      end
      if (rf_rd_wb_match[1]) begin
        operand_b_fw_sel_o = SEL_FW_WB;
      end
    end

    // Execute is younger and wins; unused while a load stalls
    if (rf_we_ex) begin
      if (rf_rd_ex_match[0]) begin
        operand_a_fw_sel_o = SEL_FW_EX;
      end
      if (rf_rd_ex_match[1]) begin
        operand_b_fw_sel_o = SEL_FW_EX;
      end
    end
  end

  // Stall only ever comes from a live load in EX
  always_comb begin
    a_stall_needs_load: assert final (!load_stall_o || (ex_valid_i && lsu_en_ex_i))
      else $error("load stall without load in execute");
  end

  // An address in EX is never forwarded out of a load
  always_comb begin
    a_no_fw_from_load: assert final (
      !(load_ex && ((operand_a_fw_sel_o == SEL_FW_EX) || (operand_b_fw_sel_o == SEL_FW_EX))) ||
      load_stall_o
    ) else $error("execute forward of a load without stall");
  end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file #(
  parameter int unsigned RF_NUM_READ_PORTS = 2
) (
  input  logic               clk,
  input  logic               rst_n_i,
  input  core_pkg::rf_addr_t raddr_i [RF_NUM_READ_PORTS],
  output core_pkg::word_t    rdata_o [RF_NUM_READ_PORTS],
  input  logic               we_i,
  input  core_pkg::rf_addr_t waddr_i,
  input  core_pkg::word_t    wdata_i
);

  import core_pkg::*;

  // x1..x31, x0 has no storage
  word_t regs_q [1:31];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 1; r < 32; r++) begin
        regs_q[r] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational read, old value while the same address is written
  for (genvar p = 0; p < RF_NUM_READ_PORTS; p++) begin : gen_read
    assign rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs_q[raddr_i[p]];
  end

endmodule

`default_nettype wire

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
  parameter int unsigned RF_NUM_READ_PORTS = 2
) (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               stall_i,
  // Decoded controls
  input  logic               id_valid_i,
  input  logic               id_rf_we_i,
  input  core_pkg::rf_addr_t id_rf_waddr_i,
  input  core_pkg::alu_op_e  id_alu_op_i,
  input  core_pkg::word_t    id_imm_i,
  input  logic               id_use_imm_i,
  input  logic               id_lsu_en_i,
  input  logic               id_lsu_we_i,
  // Operand sources
  input  core_pkg::word_t    rf_rdata_i [RF_NUM_READ_PORTS],
  input  core_pkg::word_t    wb_wdata_i,
  input  core_pkg::fw_sel_e  operand_a_fw_sel_i,
  input  core_pkg::fw_sel_e  operand_b_fw_sel_i,
  // Execute outputs
  output logic               rf_we_o,
  output core_pkg::rf_addr_t rf_waddr_o,
  output logic               lsu_en_o,
  output logic               lsu_we_o,
  output logic               valid_o,
  output core_pkg::word_t    alu_result_o,
  output core_pkg::word_t    store_data_o
);

  import core_pkg::*;

  // Forwarded operands in decode
  word_t   op_a_fw;
  word_t   op_b_fw;
  // Decode-to-execute register
  logic    valid_q;
  logic    rf_we_q;
  logic    lsu_en_q;
  logic    lsu_we_q;
  rf_addr_t rf_waddr_q;
  alu_op_e alu_op_q;
  word_t   op_a_q;
  word_t   op_b_q;
  word_t   imm_q;
  logic    use_imm_q;
  // Second ALU input
  word_t   alu_b;

  // Same three-way pick for both operands
  function automatic word_t fw_mux(fw_sel_e sel, word_t rf, word_t ex, word_t wb);
    case (sel)
      SEL_FW_EX: return ex;
      SEL_FW_WB: return wb;
      default:   return rf;
    endcase
  endfunction

  assign op_a_fw = fw_mux(operand_a_fw_sel_i, rf_rdata_i[0], alu_result_o, wb_wdata_i);
  assign op_b_fw = fw_mux(operand_b_fw_sel_i, rf_rdata_i[1], alu_result_o, wb_wdata_i);

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  // Stall turns the slot into a bubble
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      rf_we_q  <= 1'b0;
      lsu_en_q <= 1'b0;
      lsu_we_q <= 1'b0;
    end else begin
      valid_q  <= id_valid_i && !stall_i;
      rf_we_q  <= id_rf_we_i && !stall_i;
      lsu_en_q <= id_lsu_en_i && !stall_i;
      lsu_we_q <= id_lsu_we_i && !stall_i;
    end
  end

  // Payload follows, don't care in a bubble
  always_ff @(posedge clk) begin
    rf_waddr_q <= id_rf_waddr_i;
    alu_op_q   <= id_alu_op_i;
    op_a_q     <= op_a_fw;
    op_b_q     <= op_b_fw;
    imm_q      <= id_imm_i;
    use_imm_q  <= id_use_imm_i;
  end

  // ALU, also the byte address for LW and SW
  assign alu_b        = use_imm_q ? imm_q : op_b_q;
  assign alu_result_o = (alu_op_q == ALU_SUB) ? (op_a_q - alu_b) : (op_a_q + alu_b);

  assign rf_we_o      = rf_we_q;
  assign rf_waddr_o   = rf_waddr_q;
  assign lsu_en_o     = lsu_en_q;
  assign lsu_we_o     = lsu_we_q;
  assign valid_o      = valid_q;
  // rs2 value for stores
  assign store_data_o = op_b_q;

  // Load-use stall leaves exactly one bubble behind
  a_bubble_after_stall: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    stall_i |=> !valid_o
  ) else $error("execute valid after stall");

endmodule

`default_nettype wire

// ==== src/wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_stage #(
  parameter int unsigned DMEM_DEPTH = 64
) (
  input  logic               clk,
  input  logic               rst_n_i,
  // From execute
  input  logic               ex_rf_we_i,
  input  core_pkg::rf_addr_t ex_rf_waddr_i,
  input  logic               ex_lsu_en_i,
  input  logic               ex_lsu_we_i,
  input  logic               ex_valid_i,
  input  core_pkg::word_t    ex_alu_result_i,
  input  core_pkg::word_t    ex_store_data_i,
  // Register file write port
  output logic               rf_we_o,
  output core_pkg::rf_addr_t rf_waddr_o,
  output core_pkg::word_t    rf_wdata_o,
  output logic               valid_o
);

  import core_pkg::*;

  // Word index width
  localparam int unsigned AW = $clog2(DMEM_DEPTH);

  // Execute-to-result register
  logic     valid_q;
  logic     rf_we_q;
  logic     lsu_en_q;
  logic     lsu_we_q;
  rf_addr_t rf_waddr_q;
  word_t    alu_q;
  word_t    store_q;
  // Data memory
  word_t    dmem [DMEM_DEPTH];
  logic [AW-1:0] dmem_idx;
  word_t    load_data;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      rf_we_q  <= 1'b0;
      lsu_en_q <= 1'b0;
      lsu_we_q <= 1'b0;
    end else begin
      valid_q  <= ex_valid_i;
      rf_we_q  <= ex_rf_we_i && ex_valid_i;
      lsu_en_q <= ex_lsu_en_i && ex_valid_i;
      lsu_we_q <= ex_lsu_we_i && ex_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    rf_waddr_q <= ex_rf_waddr_i;
    alu_q      <= ex_alu_result_i;
    store_q    <= ex_store_data_i;
  end

  ////////////////////////////////////////
  // Data memory
  ////////////////////////////////////////

  // Byte address to word index, low two bits dropped
  assign dmem_idx = alu_q[AW+1:2];

  // Store lands at the edge closing its result cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int k = 0; k < DMEM_DEPTH; k++) begin
        dmem[k] <= '0;
      end
    end else if (valid_q && lsu_en_q && lsu_we_q) begin
      dmem[dmem_idx] <= store_q;
    end
  end

  // Single-cycle read, never busy
  assign load_data = dmem[dmem_idx];

  // Load data or ALU result goes back
  assign rf_we_o    = rf_we_q && valid_q;
  assign rf_waddr_o = rf_waddr_q;
  assign rf_wdata_o = lsu_en_q ? load_data : alu_q;
  assign valid_o    = valid_q;

  // r0 writes are filtered in decode, none may arrive here
  a_no_r0_write: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    rf_we_o |-> (rf_waddr_o != '0)
  ) else $error("write enable to register 0");

endmodule

`default_nettype wire

// ==== src/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter int unsigned RF_NUM_READ_PORTS = 2,
  parameter int unsigned DMEM_DEPTH        = 64
) (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               instr_valid_i,
  input  core_pkg::instr_u   instr_i,
  output logic               id_stall_o,
  output logic               wb_valid_o,
  output core_pkg::rf_addr_t wb_waddr_o,
  output core_pkg::word_t    wb_wdata_o
);

  import core_pkg::*;

  ////////////////////////////////////////
  // Stage wires
  ////////////////////////////////////////

  // Decode
  logic [RF_NUM_READ_PORTS-1:0] id_rf_re;
  rf_addr_t id_rf_raddr [RF_NUM_READ_PORTS];
  logic     id_rf_we;
  rf_addr_t id_rf_waddr;
  alu_op_e  id_alu_op;
  word_t    id_imm;
  logic     id_use_imm;
  logic     id_lsu_en;
  logic     id_lsu_we;
  logic     id_valid;
  word_t    rf_rdata [RF_NUM_READ_PORTS];
  // Bypass
  fw_sel_e  op_a_sel;
  fw_sel_e  op_b_sel;
  logic     load_stall;
  // Execute
  logic     ex_rf_we;
  rf_addr_t ex_rf_waddr;
  logic     ex_lsu_en;
  logic     ex_lsu_we;
  logic     ex_valid;
  word_t    ex_alu_result;
  word_t    ex_store_data;
  // Result
  logic     wb_rf_we;
  rf_addr_t wb_rf_waddr;
  word_t    wb_rf_wdata;
  logic     wb_valid;

  id_decoder #(
    .RF_NUM_READ_PORTS(RF_NUM_READ_PORTS)
  ) u_id_decoder (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .stall_i      (load_stall),
    .rf_re_o      (id_rf_re),
    .rf_raddr_o   (id_rf_raddr),
    .rf_we_o      (id_rf_we),
    .rf_waddr_o   (id_rf_waddr),
    .alu_op_o     (id_alu_op),
    .imm_o        (id_imm),
    .use_imm_o    (id_use_imm),
    .lsu_en_o     (id_lsu_en),
    .lsu_we_o     (id_lsu_we),
    .valid_o      (id_valid)
  );

  controller_bypass #(
    .RF_NUM_READ_PORTS(RF_NUM_READ_PORTS)
  ) u_controller_bypass (
    .rf_re_id_i        (id_rf_re),
    .rf_raddr_id_i     (id_rf_raddr),
    .id_valid_i        (id_valid),
    .rf_we_ex_i        (ex_rf_we),
    .rf_waddr_ex_i     (ex_rf_waddr),
    .lsu_en_ex_i       (ex_lsu_en),
    .ex_valid_i        (ex_valid),
    .rf_we_wb_i        (wb_rf_we),
    .rf_waddr_wb_i     (wb_rf_waddr),
    .wb_valid_i        (wb_valid),
    .operand_a_fw_sel_o(op_a_sel),
    .operand_b_fw_sel_o(op_b_sel),
    .load_stall_o      (load_stall)
  );

  register_file #(
    .RF_NUM_READ_PORTS(RF_NUM_READ_PORTS)
  ) u_register_file (
    .clk    (clk),
    .rst_n_i(rst_n_i),
    .raddr_i(id_rf_raddr),
    .rdata_o(rf_rdata),
    .we_i   (wb_rf_we),
    .waddr_i(wb_rf_waddr),
    .wdata_i(wb_rf_wdata)
  );

  ex_stage #(
    .RF_NUM_READ_PORTS(RF_NUM_READ_PORTS)
  ) u_ex_stage (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .stall_i           (load_stall),
    .id_valid_i        (id_valid),
    .id_rf_we_i        (id_rf_we),
    .id_rf_waddr_i     (id_rf_waddr),
    .id_alu_op_i       (id_alu_op),
    .id_imm_i          (id_imm),
    .id_use_imm_i      (id_use_imm),
    .id_lsu_en_i       (id_lsu_en),
    .id_lsu_we_i       (id_lsu_we),
    .rf_rdata_i        (rf_rdata),
    .wb_wdata_i        (wb_rf_wdata),
    .operand_a_fw_sel_i(op_a_sel),
    .operand_b_fw_sel_i(op_b_sel),
    .rf_we_o           (ex_rf_we),
    .rf_waddr_o        (ex_rf_waddr),
    .lsu_en_o          (ex_lsu_en),
    .lsu_we_o          (ex_lsu_we),
    .valid_o           (ex_valid),
    .alu_result_o      (ex_alu_result),
    .store_data_o      (ex_store_data)
  );

  wb_stage #(
    .DMEM_DEPTH(DMEM_DEPTH)
  ) u_wb_stage (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .ex_rf_we_i     (ex_rf_we),
    .ex_rf_waddr_i  (ex_rf_waddr),
    .ex_lsu_en_i    (ex_lsu_en),
    .ex_lsu_we_i    (ex_lsu_we),
    .ex_valid_i     (ex_valid),
    .ex_alu_result_i(ex_alu_result),
    .ex_store_data_i(ex_store_data),
    .rf_we_o        (wb_rf_we),
    .rf_waddr_o     (wb_rf_waddr),
    .rf_wdata_o     (wb_rf_wdata),
    .valid_o        (wb_valid)
  );

  // Source holds its word while a load-use stall is up
  assign id_stall_o = load_stall;
  assign wb_valid_o = wb_rf_we;
  assign wb_waddr_o = wb_rf_waddr;
  assign wb_wdata_o = wb_rf_wdata;

endmodule

`default_nettype wire

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;

  localparam int unsigned CLK_PERIOD  = 100;
  localparam int unsigned DRIVE_DELAY = 10;
  localparam int unsigned MAX_ROWS    = 48;
  localparam int unsigned RAND_COUNT  = 40;
  localparam int unsigned DRAIN_LIMIT = 8;

  logic             clk;
  logic             rst_n_i;
  logic             instr_valid_i;
  core_pkg::instr_u instr_i;
  logic             id_stall_o;
  logic             wb_valid_o;
  logic [4:0]       wb_waddr_o;
  logic [31:0]      wb_wdata_o;

  // Stimulus table with one entry per instruction
  int          row_test  [MAX_ROWS];
  logic [31:0] row_word  [MAX_ROWS];
  logic        row_we    [MAX_ROWS];
  logic [4:0]  row_rd    [MAX_ROWS];
  logic [31:0] row_val   [MAX_ROWS];
  int          row_stall [MAX_ROWS];
  int          num_rows;

  // Writes still to retire in issue order
  logic [4:0]  exp_rd_q  [$];
  logic [31:0] exp_val_q [$];
  // Reference register state
  logic [31:0] ref_regs  [32];

  int err_count;
  int check_count;
  int tests_passed;
  int tests_failed;
  int watchdog_cycles;

  core_top #(
    .RF_NUM_READ_PORTS(2),
    .DMEM_DEPTH       (64)
  ) dut (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .id_stall_o   (id_stall_o),
    .wb_valid_o   (wb_valid_o),
    .wb_waddr_o   (wb_waddr_o),
    .wb_wdata_o   (wb_wdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Instruction encoding in RV32I formats
  ////////////////////////////////////////

  function automatic logic [31:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] sub_word(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  // Immediate split around the register fields
  function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic string test_title(input int t);
    case (t)
      1:       return "independent alu";
      2:       return "alu forwarding";
      3:       return "store then load";
      4:       return "load-use stall";
      5:       return "register 0";
      default: return "random alu";
    endcase
  endfunction

  ////////////////////////////////////////
  // Table
  ////////////////////////////////////////

  task automatic row_add(input int t, input logic [31:0] word, input logic we,
                         input logic [4:0] rd, input logic [31:0] val, input int stall);
    row_test[num_rows]  = t;
    row_word[num_rows]  = word;
    row_we[num_rows]    = we;
    row_rd[num_rows]    = rd;
    row_val[num_rows]   = val;
    row_stall[num_rows] = stall;
    num_rows++;
  endtask

  // Last column counts stall cycles seen while that row waits at the input
  task automatic build_table();
    num_rows = 0;
    row_add(1, addi_word(5'd1, 5'd0, 12'd5),     1'b1, 5'd1, 32'd5, 0);
    row_add(1, addi_word(5'd2, 5'd0, 12'hFFD),   1'b1, 5'd2, 32'hFFFF_FFFD, 0);
    row_add(1, addi_word(5'd3, 5'd0, 12'd100),   1'b1, 5'd3, 32'd100, 0);
    row_add(1, addi_word(5'd0, 5'd0, 12'd7),     1'b0, 5'd0, 32'd0, 0);
    row_add(1, addi_word(5'd5, 5'd0, 12'h7FF),   1'b1, 5'd5, 32'd2047, 0);
    row_add(1, add_word(5'd6, 5'd1, 5'd3),       1'b1, 5'd6, 32'd105, 0);
    row_add(1, sub_word(5'd7, 5'd2, 5'd1),       1'b1, 5'd7, 32'hFFFF_FFF8, 0);
    row_add(1, sub_word(5'd0, 5'd5, 5'd1),       1'b0, 5'd0, 32'd0, 0);
    // Distance one reads execute and distance two reads result
    row_add(2, addi_word(5'd8, 5'd0, 12'd10),    1'b1, 5'd8, 32'd10, 0);
    row_add(2, add_word(5'd9, 5'd8, 5'd8),       1'b1, 5'd9, 32'd20, 0);
    row_add(2, addi_word(5'd10, 5'd9, 12'd1),    1'b1, 5'd10, 32'd21, 0);
    row_add(2, sub_word(5'd11, 5'd9, 5'd10),     1'b1, 5'd11, 32'hFFFF_FFFF, 0);
    row_add(2, addi_word(5'd12, 5'd0, 12'd3),    1'b1, 5'd12, 32'd3, 0);
    row_add(2, add_word(5'd13, 5'd11, 5'd12),    1'b1, 5'd13, 32'd2, 0);
    row_add(2, add_word(5'd14, 5'd12, 5'd13),    1'b1, 5'd14, 32'd5, 0);
    // Memory starts at zero
    row_add(3, lw_word(5'd20, 5'd0, 12'd4),      1'b1, 5'd20, 32'd0, 0);
    row_add(3, addi_word(5'd15, 5'd0, 12'd64),   1'b1, 5'd15, 32'd64, 0);
    row_add(3, addi_word(5'd16, 5'd0, 12'h123),  1'b1, 5'd16, 32'h123, 0);
    row_add(3, sw_word(5'd16, 5'd15, 12'd8),     1'b0, 5'd0, 32'd0, 0);
    row_add(3, lw_word(5'd17, 5'd15, 12'd8),     1'b1, 5'd17, 32'h123, 0);
    row_add(3, addi_word(5'd18, 5'd0, 12'd7),    1'b1, 5'd18, 32'd7, 0);
    row_add(3, add_word(5'd19, 5'd17, 5'd18),    1'b1, 5'd19, 32'h12A, 0);
    // Use right after a load on port a and then on port b
    row_add(4, addi_word(5'd21, 5'd0, 12'h555),  1'b1, 5'd21, 32'h555, 0);
    row_add(4, sw_word(5'd21, 5'd0, 12'd16),     1'b0, 5'd0, 32'd0, 0);
    row_add(4, lw_word(5'd22, 5'd0, 12'd16),     1'b1, 5'd22, 32'h555, 0);
    row_add(4, add_word(5'd23, 5'd22, 5'd21),    1'b1, 5'd23, 32'hAAA, 0);
    row_add(4, addi_word(5'd24, 5'd23, 12'd1),   1'b1, 5'd24, 32'hAAB, 1);
    row_add(4, lw_word(5'd25, 5'd0, 12'd16),     1'b1, 5'd25, 32'h555, 0);
    row_add(4, sub_word(5'd26, 5'd24, 5'd25),    1'b1, 5'd26, 32'h556, 0);
    row_add(4, addi_word(5'd27, 5'd0, 12'd1),    1'b1, 5'd27, 32'd1, 1);
    // x0 as destination right before a read of x0
    row_add(5, addi_word(5'd0, 5'd0, 12'd55),    1'b0, 5'd0, 32'd0, 0);
    row_add(5, add_word(5'd29, 5'd0, 5'd0),      1'b1, 5'd29, 32'd0, 0);
    row_add(5, sub_word(5'd0, 5'd21, 5'd22),     1'b0, 5'd0, 32'd0, 0);
    row_add(5, addi_word(5'd30, 5'd0, 12'd9),    1'b1, 5'd30, 32'd9, 0);
    row_add(5, lw_word(5'd0, 5'd0, 12'd16),      1'b0, 5'd0, 32'd0, 0);
    row_add(5, add_word(5'd31, 5'd0, 5'd0),      1'b1, 5'd31, 32'd0, 0);
    row_add(5, addi_word(5'd20, 5'd0, 12'hFFF),  1'b1, 5'd20, 32'hFFFF_FFFF, 0);
  endtask

  ////////////////////////////////////////
  // Drive and drain
  ////////////////////////////////////////

  // Hold the word until an edge with no stall takes it
  task automatic apply(input logic [31:0] word, input logic we, input logic [4:0] rd,
                       input logic [31:0] val, input int exp_stall);
    int   stalls;
    logic stalled;
    stalls = 0;
    if (we) begin
      exp_rd_q.push_back(rd);
      exp_val_q.push_back(val);
      ref_regs[rd] = val;
    end
    instr_valid_i = 1'b1;
    instr_i       = word;
    do begin
      @(negedge clk);
      stalled = id_stall_o;
      if (stalled) begin
        stalls++;
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end while (stalled);
    check_count++;
    if (stalls != exp_stall) begin
      $display("mismatch at %0d ns: %0d stall cycles on %08h, expected %0d",
               $time, stalls, word, exp_stall);
      err_count++;
    end
  endtask

  task automatic drain();
    int waited;
    waited        = 0;
    instr_valid_i = 1'b0;
    while ((exp_rd_q.size() != 0) && (waited < DRAIN_LIMIT)) begin
      @(posedge clk);
      waited++;
    end
    // A few idle cycles so a late extra write still shows up
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    if (exp_rd_q.size() != 0) begin
      $display("missing write: %0d expected results never retired", exp_rd_q.size());
      err_count++;
      exp_rd_q.delete();
      exp_val_q.delete();
    end
  endtask

  task automatic run_random();
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] word;
    logic [31:0] val;
    for (int i = 0; i < RAND_COUNT; i++) begin
      kind = $urandom_range(2, 0);
      rd   = 5'($urandom_range(31, 0));
      rs1  = 5'($urandom_range(31, 0));
      rs2  = 5'($urandom_range(31, 0));
      imm  = 12'($urandom);
      case (kind)
        0: begin
          word = add_word(rd, rs1, rs2);
          val  = ref_regs[rs1] + ref_regs[rs2];
        end
        1: begin
          word = sub_word(rd, rs1, rs2);
          val  = ref_regs[rs1] - ref_regs[rs2];
        end
        default: begin
          word = addi_word(rd, rs1, imm);
          val  = ref_regs[rs1] + {{20{imm[11]}}, imm};
        end
      endcase
      // ALU-only stream never stalls
      apply(word, rd != 5'd0, rd, val, 0);
    end
  endtask

  task automatic report_test(input int t, input int errors);
    if (errors == 0) begin
      tests_passed++;
      $display("test %0d (%s): ok", t, test_title(t));
    end else begin
      tests_failed++;
      $display("test %0d (%s): %0d errors", t, test_title(t), errors);
    end
  endtask

  ////////////////////////////////////////
  // Retire monitor
  ////////////////////////////////////////

  always @(negedge clk) begin : retire_monitor
    logic [4:0]  exp_rd;
    logic [31:0] exp_val;
    if (rst_n_i && wb_valid_o) begin
      check_count++;
      if (exp_rd_q.size() == 0) begin
        $display("unexpected write at %0d ns: x%0d <= %08h with nothing left to retire",
                 $time, wb_waddr_o, wb_wdata_o);
        err_count++;
      end else begin
        exp_rd  = exp_rd_q.pop_front();
        exp_val = exp_val_q.pop_front();
        if ((wb_waddr_o !== exp_rd) || (wb_wdata_o !== exp_val)) begin
          $display("mismatch at %0d ns: wrote x%0d = %08h, expected x%0d = %08h",
                   $time, wb_waddr_o, wb_wdata_o, exp_rd, exp_val);
          err_count++;
        end
      end
    end
  end

  // Four cycles per issued row plus margin for reset and drains
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin : main_sequence
    int test_err;
    void'($urandom(81025));
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    err_count     = 0;
    check_count   = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    for (int k = 0; k < 32; k++) begin
      ref_regs[k] = '0;
    end
    build_table();
    watchdog_cycles = (num_rows + RAND_COUNT) * 4 + 50;

    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;

    for (int t = 1; t <= 5; t++) begin
      test_err = err_count;
      for (int r = 0; r < num_rows; r++) begin
        if (row_test[r] == t) begin
          apply(row_word[r], row_we[r], row_rd[r], row_val[r], row_stall[r]);
        end
      end
      drain();
      report_test(t, err_count - test_err);
    end

    test_err = err_count;
    run_random();
    drain();
    report_test(6, err_count - test_err);

    $display("tests: %0d passed, %0d failed; checks: %0d; errors: %0d",
             tests_passed, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
src/core_pkg.sv
src/id_decoder.sv
src/controller_bypass.sv
src/register_file.sv
src/ex_stage.sv
src/wb_stage.sv
src/core_top.sv
bench/core_tb.sv

// ==== Bender.yml ====
package:
  name: core_slice

sources:
  - files:
      - src/core_pkg.sv
      - src/id_decoder.sv
      - src/controller_bypass.sv
      - src/register_file.sv
      - src/ex_stage.sv
      - src/wb_stage.sv
      - src/core_top.sv
  - target: simulation
    files:
      - bench/core_tb.sv
